// ==== frame_tx_pkg.sv ====
package frame_tx_pkg;

    ////////////////////
    // data types
    ////////////////////

    // one byte on the slave port
    typedef logic [7:0]  byte_t;

    // ddr readback word
    typedef logic [31:0] rb_word_t;

    // raw adc sample
    typedef logic [15:0] adc_sample_t;

    // announced byte count
    typedef logic [15:0] len_t;

    // frame type code sent as header
    typedef logic [15:0] type_code_t;

    ////////////////////
    // arbitration
    ////////////////////

    localparam int unsigned CHAN_NUM = 2;

    // bit 0 readback, bit 1 adc
    typedef logic [CHAN_NUM-1:0] chan_t;

    ////////////////////
    // buffers
    ////////////////////

    localparam int unsigned FIFO_DEPTH = 2048;
    localparam int unsigned FIFO_AW    = $clog2(FIFO_DEPTH);

    // readback words per frame
    typedef logic [FIFO_AW-1:0] word_cnt_t;

    ////////////////////
    // frame format
    ////////////////////

    localparam type_code_t  READBACK_TYPE     = 16'h1002;
    localparam type_code_t  RAWADC_TYPE       = 16'h1004;
    localparam int unsigned HEADER_BYTES      = 2;
    localparam int unsigned RB_WORD_BYTES     = $bits(rb_word_t) / 8;
    localparam int unsigned ADC_SAMPLE_BYTES  = $bits(adc_sample_t) / 8;

    // adc decimation and framing
    localparam int unsigned ADC_DECIM         = 100;
    localparam int unsigned DECIM_CNT_W       = $clog2(ADC_DECIM);
    localparam int unsigned ADC_FRAME_SAMPLES = 512;
    localparam int unsigned SAMPLE_CNT_W      = $clog2(ADC_FRAME_SAMPLES);

endpackage

// ==== sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
    parameter type payload_t = frame_tx_pkg::byte_t
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     clear_i,
    input  logic     wr_en_i,
    input  payload_t wr_data_i,
    input  logic     rd_en_i,
    output payload_t rd_data_o,
    output logic     empty_o
);

    payload_t                        mem [frame_tx_pkg::FIFO_DEPTH];
    logic [frame_tx_pkg::FIFO_AW-1:0] wr_ptr;
    logic [frame_tx_pkg::FIFO_AW-1:0] rd_ptr;
    logic [frame_tx_pkg::FIFO_AW:0]   count;
    logic                            full;
    logic                            do_wr;
    logic                            do_rd;

    assign full    = (count == frame_tx_pkg::FIFO_DEPTH);
    assign empty_o = (count == '0);

    // a write into a full buffer is dropped
    assign do_wr = wr_en_i && !full;
    assign do_rd = rd_en_i && !empty_o;

    // first word falls through
    assign rd_data_o = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    ////////////////////
    // pointers and fill level
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== readback_capture.sv ====
`timescale 1ns/10ps

module readback_capture (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    readback_vld_i,
    input  logic                    readback_last_i,
    output frame_tx_pkg::word_cnt_t frame_words_o,
    output logic                    req_o
);

    frame_tx_pkg::word_cnt_t word_cnt;
    logic                    last_word;

    // last only counts together with its valid
    assign last_word = readback_vld_i && readback_last_i;

    // words seen so far in this burst
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            word_cnt <= '0;
        end else if (last_word) begin
            word_cnt <= '0;
        end else if (readback_vld_i) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // frame length includes the last word
    always_ff @(posedge clk_i) begin
        if (last_word) begin
            frame_words_o <= word_cnt + 1'b1;
        end
    end

    // one cycle request per burst
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_o <= 1'b0;
        end else begin
            req_o <= last_word;
        end
    end

endmodule

// ==== adc_decimator.sv ====
`timescale 1ns/10ps

module adc_decimator (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      raw_adc_cfg_i,
    input  logic                      raw_adc_vld_i,
    input  frame_tx_pkg::adc_sample_t raw_adc_data_i,
    output logic                      wr_en_o,
    output frame_tx_pkg::adc_sample_t wr_data_o,
    output logic                      flush_o,
    output logic                      req_o
);

    logic [frame_tx_pkg::DECIM_CNT_W-1:0]  decim_cnt;
    logic [frame_tx_pkg::SAMPLE_CNT_W-1:0] sample_cnt;
    logic                                 decim_last;
    logic                                 keep;
    logic                                 frame_end;

    assign decim_last = (decim_cnt == frame_tx_pkg::DECIM_CNT_W'(frame_tx_pkg::ADC_DECIM - 1));
    assign keep       = raw_adc_cfg_i && raw_adc_vld_i && decim_last;
    assign frame_end  = keep &&
        (sample_cnt == frame_tx_pkg::SAMPLE_CNT_W'(frame_tx_pkg::ADC_FRAME_SAMPLES - 1));

    ////////////////////
    // counters
    ////////////////////

    // position inside the decimation period
    always_ff @(posedge clk_i) begin
        if (rst_i || !raw_adc_cfg_i) begin
            decim_cnt <= '0;
        end else if (raw_adc_vld_i) begin
            if (decim_last) begin
                decim_cnt <= '0;
            end else begin
                decim_cnt <= decim_cnt + 1'b1;
            end
        end
    end

    // kept samples in the current frame, wraps at frame size
    always_ff @(posedge clk_i) begin
        if (rst_i || !raw_adc_cfg_i) begin
            sample_cnt <= '0;
        end else if (keep) begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    ////////////////////
    // buffer side
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_en_o <= 1'b0;
            req_o   <= 1'b0;
            flush_o <= 1'b0;
        end else begin
            wr_en_o <= keep;
            req_o   <= frame_end;
            flush_o <= !raw_adc_cfg_i;
        end
    end

    // low byte goes first on the wire
    always_ff @(posedge clk_i) begin
        wr_data_o <= {raw_adc_data_i[7:0], raw_adc_data_i[15:8]};
    end

endmodule

// ==== frame_arbiter.sv ====
`timescale 1ns/10ps

module frame_arbiter (
    input  logic                clk_i,
    input  logic                rst_i,
    input  frame_tx_pkg::chan_t req_i,
    input  logic                slave_tx_ack_i,
    output frame_tx_pkg::chan_t grant_o
);

    frame_tx_pkg::chan_t pending;
    frame_tx_pkg::chan_t pending_nxt;
    frame_tx_pkg::chan_t ptr;
    frame_tx_pkg::chan_t ptr_rot;
    logic                ack_q;

    // one empty cycle after every acknowledge
    assign grant_o = ack_q ? '0 : (pending & ptr);

    assign ptr_rot = {ptr[frame_tx_pkg::CHAN_NUM-2:0], ptr[frame_tx_pkg::CHAN_NUM-1]};

    // a new request wins over the clear
    assign pending_nxt = req_i |
        (pending & ~(grant_o & {frame_tx_pkg::CHAN_NUM{slave_tx_ack_i}}));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending <= '0;
            ack_q   <= 1'b0;
        end else begin
            pending <= pending_nxt;
            ack_q   <= slave_tx_ack_i && (grant_o != '0);
        end
    end

    ////////////////////
    // round robin pointer
    ////////////////////

    // moves only while idle, next channel in turn gets first look
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr <= frame_tx_pkg::chan_t'(1);
        end else if (grant_o == '0) begin
            if ((pending_nxt & ptr_rot) != '0) begin
                ptr <= ptr_rot;
            end else if ((pending_nxt & ptr) != '0) begin
                ptr <= ptr;
            end else begin
                ptr <= ptr_rot;
            end
        end
    end

endmodule

// ==== frame_serializer.sv ====
`timescale 1ns/10ps

module frame_serializer (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  frame_tx_pkg::chan_t       grant_i,
    input  frame_tx_pkg::word_cnt_t   frame_words_i,
    input  frame_tx_pkg::rb_word_t    rb_data_i,
    input  logic                      rb_empty_i,
    output logic                      rb_rd_en_o,
    input  frame_tx_pkg::adc_sample_t adc_data_i,
    input  logic                      adc_empty_i,
    output logic                      adc_rd_en_o,
    output logic                      slave_tx_byte_num_en_o,
    output frame_tx_pkg::len_t        slave_tx_byte_num_o,
    output logic                      slave_tx_byte_en_o,
    output frame_tx_pkg::byte_t       slave_tx_byte_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR0,
        S_HDR1,
        S_PAY,
        S_DONE
    } state_t;

    state_t                   state;
    frame_tx_pkg::chan_t      chan_q;
    frame_tx_pkg::word_cnt_t  words_left;
    frame_tx_pkg::rb_word_t   shift_q;
    logic [1:0]               shift_cnt;
    frame_tx_pkg::type_code_t type_code;
    frame_tx_pkg::rb_word_t   pay_word;
    logic                     pay_empty;
    logic                     pop;

    // selected channel
    assign type_code = chan_q[0] ? frame_tx_pkg::READBACK_TYPE : frame_tx_pkg::RAWADC_TYPE;
    assign pay_empty = chan_q[0] ? rb_empty_i : adc_empty_i;

    // words are left aligned so bytes always leave from the top
    assign pay_word  = chan_q[0] ? rb_data_i : {adc_data_i, 16'h0000};

    // next word only when the shifter has run dry
    assign pop = (state == S_PAY) && (shift_cnt == '0) && (words_left != '0) && !pay_empty;

    assign rb_rd_en_o  = pop && chan_q[0];
    assign adc_rd_en_o = pop && chan_q[1];

    ////////////////////
    // frame sequencer
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state                  <= S_IDLE;
            slave_tx_byte_num_en_o <= 1'b0;
            slave_tx_byte_en_o     <= 1'b0;
            shift_cnt              <= '0;
        end else begin
            slave_tx_byte_num_en_o <= 1'b0;
            slave_tx_byte_en_o     <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (grant_i != '0) begin
                        slave_tx_byte_num_en_o <= 1'b1;
                        shift_cnt              <= '0;
                        state                  <= S_HDR0;
                    end
                end
                S_HDR0: begin
                    slave_tx_byte_en_o <= 1'b1;
                    state              <= S_HDR1;
                end
                S_HDR1: begin
                    slave_tx_byte_en_o <= 1'b1;
                    state              <= S_PAY;
                end
                S_PAY: begin
                    if (shift_cnt != '0) begin
                        slave_tx_byte_en_o <= 1'b1;
                        shift_cnt          <= shift_cnt - 1'b1;
                    end else if (pop) begin
                        slave_tx_byte_en_o <= 1'b1;
                        if (chan_q[0]) begin
                            shift_cnt <= 2'(frame_tx_pkg::RB_WORD_BYTES - 1);
                        end else begin
                            shift_cnt <= 2'(frame_tx_pkg::ADC_SAMPLE_BYTES - 1);
                        end
                    end else if (words_left == '0) begin
                        state <= S_DONE;
                    end
                end
                // wait for the acknowledge to drop the grant
                S_DONE: begin
                    if (grant_i == '0) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // payload path
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (state == S_IDLE) begin
            chan_q <= grant_i;
            if (grant_i[0]) begin
                slave_tx_byte_num_o <= frame_tx_pkg::len_t'(frame_words_i) *
                    frame_tx_pkg::len_t'(frame_tx_pkg::RB_WORD_BYTES) +
                    frame_tx_pkg::len_t'(frame_tx_pkg::HEADER_BYTES);
                words_left <= frame_words_i;
            end else begin
                slave_tx_byte_num_o <= frame_tx_pkg::len_t'(frame_tx_pkg::ADC_FRAME_SAMPLES *
                    frame_tx_pkg::ADC_SAMPLE_BYTES + frame_tx_pkg::HEADER_BYTES);
                words_left <= frame_tx_pkg::word_cnt_t'(frame_tx_pkg::ADC_FRAME_SAMPLES);
            end
        end

        case (state)
            S_HDR0: slave_tx_byte_o <= type_code[15:8];
            S_HDR1: slave_tx_byte_o <= type_code[7:0];
            default: begin
                if (shift_cnt != '0) begin
                    slave_tx_byte_o <= shift_q[31:24];
                    shift_q         <= {shift_q[23:0], 8'h00};
                end else if (pop) begin
                    // first byte leaves straight from the buffer
                    slave_tx_byte_o <= pay_word[31:24];
                    shift_q         <= {pay_word[23:0], 8'h00};
                    words_left      <= words_left - 1'b1;
                end
            end
        endcase
    end

endmodule

// ==== frame_tx_top.sv ====
`timescale 1ns/10ps

module frame_tx_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      readback_vld_i,
    input  logic                      readback_last_i,
    input  frame_tx_pkg::rb_word_t    readback_data_i,
    input  logic                      raw_adc_cfg_i,
    input  logic                      raw_adc_vld_i,
    input  frame_tx_pkg::adc_sample_t raw_adc_data_i,
    input  logic                      slave_tx_ack_i,
    output logic                      slave_tx_byte_num_en_o,
    output frame_tx_pkg::len_t        slave_tx_byte_num_o,
    output logic                      slave_tx_byte_en_o,
    output frame_tx_pkg::byte_t       slave_tx_byte_o
);

    frame_tx_pkg::word_cnt_t   frame_words;
    logic                      rb_req;
    logic                      rb_rd_en;
    logic                      rb_empty;
    frame_tx_pkg::rb_word_t    rb_rd_data;
    logic                      adc_wr_en;
    frame_tx_pkg::adc_sample_t adc_wr_data;
    logic                      adc_flush;
    logic                      adc_req;
    logic                      adc_rd_en;
    logic                      adc_empty;
    frame_tx_pkg::adc_sample_t adc_rd_data;
    frame_tx_pkg::chan_t       grant;

    ////////////////////
    // producers
    ////////////////////

    readback_capture readback_capture_inst (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .readback_vld_i  (readback_vld_i),
        .readback_last_i (readback_last_i),
        .frame_words_o   (frame_words),
        .req_o           (rb_req)
    );

    adc_decimator adc_decimator_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .raw_adc_cfg_i  (raw_adc_cfg_i),
        .raw_adc_vld_i  (raw_adc_vld_i),
        .raw_adc_data_i (raw_adc_data_i),
        .wr_en_o        (adc_wr_en),
        .wr_data_o      (adc_wr_data),
        .flush_o        (adc_flush),
        .req_o          (adc_req)
    );

    ////////////////////
    // buffers
    ////////////////////

    // every readback word is stored
    sync_fifo #(.payload_t(frame_tx_pkg::rb_word_t)) rb_fifo_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .clear_i   (1'b0),
        .wr_en_i   (readback_vld_i),
        .wr_data_i (readback_data_i),
        .rd_en_i   (rb_rd_en),
        .rd_data_o (rb_rd_data),
        .empty_o   (rb_empty)
    );

    sync_fifo #(.payload_t(frame_tx_pkg::adc_sample_t)) adc_fifo_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .clear_i   (adc_flush),
        .wr_en_i   (adc_wr_en),
        .wr_data_i (adc_wr_data),
        .rd_en_i   (adc_rd_en),
        .rd_data_o (adc_rd_data),
        .empty_o   (adc_empty)
    );

    ////////////////////
    // consumer
    ////////////////////

    frame_arbiter frame_arbiter_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_i          ({adc_req, rb_req}),
        .slave_tx_ack_i (slave_tx_ack_i),
        .grant_o        (grant)
    );

    frame_serializer frame_serializer_inst (
        .clk_i                  (clk_i),
        .rst_i                  (rst_i),
        .grant_i                (grant),
        .frame_words_i          (frame_words),
        .rb_data_i              (rb_rd_data),
        .rb_empty_i             (rb_empty),
        .rb_rd_en_o             (rb_rd_en),
        .adc_data_i             (adc_rd_data),
        .adc_empty_i            (adc_empty),
        .adc_rd_en_o            (adc_rd_en),
        .slave_tx_byte_num_en_o (slave_tx_byte_num_en_o),
        .slave_tx_byte_num_o    (slave_tx_byte_num_o),
        .slave_tx_byte_en_o     (slave_tx_byte_en_o),
        .slave_tx_byte_o        (slave_tx_byte_o)
    );

endmodule

// ==== tb_frame_tx_tasks.svh ====
`ifndef TB_FRAME_TX_TASKS_SVH
`define TB_FRAME_TX_TASKS_SVH

////////////////////
// checking
////////////////////

task automatic report_failure(input string what);
    $display("failure at %0t: %s", $time, what);
    err_cnt++;
endtask

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
        $display("error at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        err_cnt++;
    end
endtask

////////////////////
// expected frames
////////////////////

// type 0x1002, then each word msb first
task automatic expect_readback();
    exp_lens.push_back(4 * rb_words.size() + 2);
    exp_bytes.push_back(8'h10);
    exp_bytes.push_back(8'h02);
    foreach (rb_words[i]) begin
        exp_bytes.push_back(rb_words[i][31:24]);
        exp_bytes.push_back(rb_words[i][23:16]);
        exp_bytes.push_back(rb_words[i][15:8]);
        exp_bytes.push_back(rb_words[i][7:0]);
    end
    frames_expected++;
endtask

// swapped samples come out low byte first
task automatic expect_adc();
    exp_lens.push_back(2 * FRAME_SAMPLES + 2);
    exp_bytes.push_back(8'h10);
    exp_bytes.push_back(8'h04);
    foreach (adc_kept[i]) begin
        exp_bytes.push_back(adc_kept[i][7:0]);
        exp_bytes.push_back(adc_kept[i][15:8]);
    end
    frames_expected++;
endtask

// consumes exactly one expected frame
task automatic compare_frame();
    int         exp_len;
    logic [7:0] exp_byte;
    if (exp_lens.size() == 0) begin
        report_failure("a frame arrived that no test expected");
    end else begin
        exp_len = exp_lens.pop_front();
        check_value("slave_tx_byte_num_o", frame_len, exp_len);
        for (int i = 0; i < exp_len; i++) begin
            exp_byte = exp_bytes.pop_front();
            if (i < got_bytes.size()) begin
                check_value($sformatf("slave_tx_byte_o[%0d]", i), got_bytes[i], exp_byte);
            end
        end
    end
endtask

////////////////////
// waits
////////////////////

task automatic wait_frames(input int limit, output bit timed_out);
    int cycles;
    cycles    = 0;
    timed_out = 1'b0;
    while (frames_done < frames_expected && cycles < limit) begin
        @(posedge clk_i);
        cycles++;
    end
    if (frames_done < frames_expected) begin
        timed_out = 1'b1;
        report_failure($sformatf("timed out waiting for frame %0d", frames_done + 1));
    end
endtask

`endif

// ==== tb_frame_tx.sv ====
`timescale 1ns/10ps

module tb_frame_tx;

    localparam int CLK_PERIOD    = 20;
    localparam int RST_CYCLES    = 5;
    localparam int DECIM         = 100;
    localparam int FRAME_SAMPLES = 512;
    localparam int WAIT_LIMIT    = 20000;
    localparam int NUM_ROWS      = 6;

    // operation kinds
    localparam int OP_RB        = 0;
    localparam int OP_ADC       = 1;
    localparam int OP_ADC_ABORT = 2;
    localparam int OP_BOTH      = 3;

    logic                      clk_i;
    logic                      rst_i;
    logic                      readback_vld_i;
    logic                      readback_last_i;
    frame_tx_pkg::rb_word_t    readback_data_i;
    logic                      raw_adc_cfg_i;
    logic                      raw_adc_vld_i;
    frame_tx_pkg::adc_sample_t raw_adc_data_i;
    logic                      slave_tx_ack_i;
    logic                      slave_tx_byte_num_en_o;
    frame_tx_pkg::len_t        slave_tx_byte_num_o;
    logic                      slave_tx_byte_en_o;
    frame_tx_pkg::byte_t       slave_tx_byte_o;

    ////////////////////
    // stimulus table
    ////////////////////

    // adc rows give kept samples and the abort row gives its partial part
    int    tbl_kind  [NUM_ROWS] = '{OP_RB, OP_RB, OP_RB, OP_ADC, OP_ADC_ABORT, OP_BOTH};
    int    tbl_count [NUM_ROWS] = '{1, 7, 300, 512, 300, 300};
    string tbl_note  [NUM_ROWS] = '{"readback burst of 1 word", "readback burst of 7 words",
                                    "readback burst of 300 words", "adc frame",
                                    "adc disabled mid frame", "readback and adc pending"};

    int          err_cnt;
    int          tests_run;
    int          tests_failed;
    int          frames_expected;
    int          frames_done;
    logic [7:0]  exp_bytes [$];
    int          exp_lens  [$];
    logic [31:0] rb_words  [$];
    logic [15:0] adc_kept  [$];

    // collector state
    logic        in_frame;
    int          frame_len;
    logic [7:0]  got_bytes [$];

    `include "tb_frame_tx_tasks.svh"

    frame_tx_top frame_tx_top_inst (
        .clk_i                  (clk_i),
        .rst_i                  (rst_i),
        .readback_vld_i         (readback_vld_i),
        .readback_last_i        (readback_last_i),
        .readback_data_i        (readback_data_i),
        .raw_adc_cfg_i          (raw_adc_cfg_i),
        .raw_adc_vld_i          (raw_adc_vld_i),
        .raw_adc_data_i         (raw_adc_data_i),
        .slave_tx_ack_i         (slave_tx_ack_i),
        .slave_tx_byte_num_en_o (slave_tx_byte_num_en_o),
        .slave_tx_byte_num_o    (slave_tx_byte_num_o),
        .slave_tx_byte_en_o     (slave_tx_byte_en_o),
        .slave_tx_byte_o        (slave_tx_byte_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    task automatic send_readback(input int n);
        logic [31:0] word;
        rb_words.delete();
        for (int i = 0; i < n; i++) begin
            @(posedge clk_i);
            word = $urandom;
            readback_vld_i  <= 1'b1;
            readback_last_i <= (i == n - 1);
            readback_data_i <= word;
            rb_words.push_back(word);
        end
        @(posedge clk_i);
        readback_vld_i  <= 1'b0;
        readback_last_i <= 1'b0;
    endtask

    // every DECIM-th valid sample is the kept one
    task automatic stream_adc(input int n);
        logic [15:0] sample;
        adc_kept.delete();
        for (int i = 1; i <= n; i++) begin
            @(posedge clk_i);
            sample = 16'($urandom);
            raw_adc_vld_i  <= 1'b1;
            raw_adc_data_i <= sample;
            if (i % DECIM == 0) begin
                adc_kept.push_back(sample);
            end
        end
        @(posedge clk_i);
        raw_adc_vld_i <= 1'b0;
    endtask

    task automatic run_row(input int kind, input int count);
        case (kind)
            OP_RB: begin
                send_readback(count);
                expect_readback();
            end
            OP_ADC: begin
                @(posedge clk_i);
                raw_adc_cfg_i <= 1'b1;
                stream_adc(count * DECIM);
                expect_adc();
            end
            OP_ADC_ABORT: begin
                stream_adc(count * DECIM);
                @(posedge clk_i);
                raw_adc_cfg_i <= 1'b0;
                repeat (4) @(posedge clk_i);
                raw_adc_cfg_i <= 1'b1;
                stream_adc(FRAME_SAMPLES * DECIM);
                expect_adc();
            end
            default: begin
                // readback ends shortly before the adc frame completes
                fork
                    begin
                        stream_adc(FRAME_SAMPLES * DECIM);
                        expect_adc();
                    end
                    begin
                        repeat (FRAME_SAMPLES * DECIM - count - 50) @(posedge clk_i);
                        send_readback(count);
                        expect_readback();
                    end
                join
            end
        endcase
    endtask

    task automatic log_test(input int num, input string note, input int err_before);
        tests_run++;
        if (err_cnt == err_before) begin
            $display("test %0d %s: passed", num, note);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, note, err_cnt - err_before);
        end
    endtask

    ////////////////////
    // byte collector
    ////////////////////

    always @(posedge clk_i) begin
        slave_tx_ack_i <= 1'b0;
        if (rst_i) begin
            in_frame = 1'b0;
            got_bytes.delete();
        end else begin
            if (slave_tx_byte_num_en_o) begin
                if (in_frame) begin
                    report_failure("byte count strobe came inside a frame");
                end
                in_frame  = 1'b1;
                frame_len = slave_tx_byte_num_o;
                got_bytes.delete();
            end
            if (slave_tx_byte_en_o) begin
                if (!in_frame) begin
                    report_failure("byte strobe came outside a frame");
                end else begin
                    got_bytes.push_back(slave_tx_byte_o);
                end
            end
            // acknowledge once the announced count is in
            if (in_frame && got_bytes.size() == frame_len) begin
                slave_tx_ack_i <= 1'b1;
                in_frame = 1'b0;
                compare_frame();
                frames_done++;
            end
        end
    end

    initial begin
        int err_before;
        bit timed_out;

        void'($urandom(66226));
        rst_i           = 1'b1;
        readback_vld_i  = 1'b0;
        readback_last_i = 1'b0;
        readback_data_i = '0;
        raw_adc_cfg_i   = 1'b0;
        raw_adc_vld_i   = 1'b0;
        raw_adc_data_i  = '0;
        slave_tx_ack_i  = 1'b0;
        in_frame        = 1'b0;
        frame_len       = 0;
        err_cnt         = 0;
        tests_run       = 0;
        tests_failed    = 0;
        frames_expected = 0;
        frames_done     = 0;
        timed_out       = 1'b0;

        repeat (RST_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        // outputs stay quiet right after reset
        err_before = err_cnt;
        repeat (5) begin
            @(posedge clk_i);
            check_value("slave_tx_byte_num_en_o", slave_tx_byte_num_en_o, 1'b0);
            check_value("slave_tx_byte_en_o", slave_tx_byte_en_o, 1'b0);
        end
        log_test(0, "idle after reset", err_before);

        for (int row = 0; row < NUM_ROWS && !timed_out; row++) begin
            err_before = err_cnt;
            run_row(tbl_kind[row], tbl_count[row]);
            wait_frames(WAIT_LIMIT, timed_out);
            log_test(row + 1, tbl_note[row], err_before);
        end

        repeat (20) @(posedge clk_i);
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
frame_tx_pkg.sv
sync_fifo.sv
readback_capture.sv
adc_decimator.sv
frame_arbiter.sv
frame_serializer.sv
frame_tx_top.sv
tb_frame_tx.sv
